// ==== common/axi_bridge_pkg.sv ====
package axi_bridge_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = 4;

    localparam logic [1:0] BURST_INCR = 2'b01;

    // axsize codes, bytes per beat
    localparam logic [2:0] SIZE_BYTE = 3'b000;
    localparam logic [2:0] SIZE_HALF = 3'b001;
    localparam logic [2:0] SIZE_WORD = 3'b010;

    localparam logic [1:0] RESP_OKAY = 2'b00;

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_ADDR,
        RD_DATA
    } rd_state_e;

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_ADDR,
        WR_DATA,
        WR_RESP
    } wr_state_e;

    // len is beats minus one, as on the AXI side
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [7:0]        len;
    } rd_req_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [7:0]        len;
        logic [STRB_W-1:0] strb; // same strobe for every beat of the burst
    } wr_req_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [7:0]        len;
        logic [2:0]        size;
        logic [1:0]        burst;
    } axi_ar_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [7:0]        len;
        logic [2:0]        size;
        logic [1:0]        burst;
    } axi_aw_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
        logic              last;
    } axi_w_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [1:0]        resp;
        logic              last;
    } axi_r_t;

    typedef struct packed {
        logic [1:0] resp;
    } axi_b_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [1:0]        resp;
    } rd_beat_t;

endpackage

// ==== hw/cache_req_arbiter.sv ====
`timescale 1ns/1ps

module cache_req_arbiter (
    input  logic                              clk,
    input  logic                              rst_i,
    input  logic                              flush_i,
    input  logic                              rd_req_valid_i,
    input  axi_bridge_pkg::rd_req_t           rd_req_i,
    input  logic                              wr_req_valid_i,
    input  axi_bridge_pkg::wr_req_t           wr_req_i,
    input  logic                              rd_busy_i,
    input  logic                              wr_busy_i,
    input  logic [axi_bridge_pkg::ADDR_W-1:0] wr_pend_addr_i,
    output logic                              rd_req_ready_o,
    output logic                              wr_req_ready_o,
    output logic                              rd_start_o,
    output axi_bridge_pkg::rd_req_t           rd_req_o,
    output logic                              wr_start_o,
    output axi_bridge_pkg::wr_req_t           wr_req_o
);

    logic rd_idle_q; // read engine free and nothing handed over
    logic wr_idle_q;
    logic rd_accept;
    logic wr_accept;
    logic rd_blocked;

    assign wr_req_ready_o = wr_idle_q && !flush_i; // nothing taken while flushing
    assign wr_accept      = wr_req_valid_i && wr_req_ready_o;

    // read-after-write check against every stage a write can sit in
    always_comb begin
        rd_blocked = 1'b0;
        if (wr_busy_i && rd_req_i.addr == wr_pend_addr_i) begin
            rd_blocked = 1'b1; // waiting for its B response
        end
        if (wr_start_o && rd_req_i.addr == wr_req_o.addr) begin
            rd_blocked = 1'b1; // handed over but engine not busy yet
        end
        if (wr_accept && rd_req_i.addr == wr_req_i.addr) begin
            rd_blocked = 1'b1; // write taken in this very cycle
        end
    end

    assign rd_req_ready_o = rd_idle_q && !rd_blocked && !flush_i;
    assign rd_accept      = rd_req_valid_i && rd_req_ready_o;

    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            rd_idle_q  <= 1'b0;
            wr_idle_q  <= 1'b0;
            rd_start_o <= 1'b0;
            wr_start_o <= 1'b0;
        end else begin
            rd_idle_q  <= !rd_busy_i && !rd_start_o && !rd_accept;
            wr_idle_q  <= !wr_busy_i && !wr_start_o && !wr_accept;
            rd_start_o <= rd_accept; // single cycle pulse
            wr_start_o <= wr_accept;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_accept) begin
            rd_req_o <= rd_req_i;
        end
        if (wr_accept) begin
            wr_req_o <= wr_req_i;
        end
    end

endmodule

// ==== axi_read/axi_read_engine.sv ====
`timescale 1ns/1ps

module axi_read_engine (
    input  logic                     clk,
    input  logic                     rst_i,
    input  logic                     flush_i,
    input  logic                     start_i,
    input  axi_bridge_pkg::rd_req_t  req_i,
    input  logic                     arready_i,
    input  logic                     rvalid_i,
    input  axi_bridge_pkg::axi_r_t   axi_r_i,
    output logic                     busy_o,
    output axi_bridge_pkg::axi_ar_t  axi_ar_o,
    output logic                     arvalid_o,
    output logic                     rready_o,
    output axi_bridge_pkg::rd_beat_t rd_beat_o,
    output logic                     rd_beat_valid_o,
    output logic                     rd_done_o
);

    axi_bridge_pkg::rd_state_e state_q;
    logic                      r_hs;

    assign busy_o = (state_q != axi_bridge_pkg::RD_IDLE);
    assign r_hs   = rvalid_i && rready_o;

    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            state_q         <= axi_bridge_pkg::RD_IDLE;
            arvalid_o       <= 1'b0;
            rready_o        <= 1'b0;
            rd_beat_valid_o <= 1'b0;
            rd_done_o       <= 1'b0;
        end else begin
            rd_beat_valid_o <= 1'b0;
            rd_done_o       <= 1'b0;
            case (state_q)
                axi_bridge_pkg::RD_IDLE: begin
                    if (start_i) begin
                        arvalid_o <= 1'b1;
                        state_q   <= axi_bridge_pkg::RD_ADDR;
                    end
                end
                axi_bridge_pkg::RD_ADDR: begin
                    // arvalid held until the slave takes it
                    if (arready_i) begin
                        arvalid_o <= 1'b0;
                        rready_o  <= 1'b1;
                        state_q   <= axi_bridge_pkg::RD_DATA;
                    end
                end
                axi_bridge_pkg::RD_DATA: begin
                    if (r_hs) begin
                        rd_beat_valid_o <= 1'b1;
                        if (axi_r_i.last) begin
                            rready_o  <= 1'b0;
                            rd_done_o <= 1'b1; // goes out with the last beat
                            state_q   <= axi_bridge_pkg::RD_IDLE;
                        end
                    end
                end
                default: begin
                    state_q <= axi_bridge_pkg::RD_IDLE;
                end
            endcase
        end
    end

    // address and beat payload
    always_ff @(posedge clk) begin
        if (state_q == axi_bridge_pkg::RD_IDLE && start_i) begin
            axi_ar_o.addr  <= req_i.addr;
            axi_ar_o.len   <= req_i.len;
            axi_ar_o.size  <= axi_bridge_pkg::SIZE_WORD; // cache lines are whole words
            axi_ar_o.burst <= axi_bridge_pkg::BURST_INCR;
        end
        if (r_hs) begin
            rd_beat_o.data <= axi_r_i.data;
            rd_beat_o.resp <= axi_r_i.resp;
        end
    end

endmodule

// ==== axi_write/axi_write_engine.sv ====
`timescale 1ns/1ps

module axi_write_engine (
    input  logic                              clk,
    input  logic                              rst_i,
    input  logic                              flush_i,
    input  logic                              start_i,
    input  axi_bridge_pkg::wr_req_t           req_i,
    input  logic [axi_bridge_pkg::DATA_W-1:0] wr_data_i,
    input  logic                              wr_data_valid_i,
    input  logic                              awready_i,
    input  logic                              wready_i,
    input  logic                              bvalid_i,
    input  axi_bridge_pkg::axi_b_t            axi_b_i,
    output logic                              busy_o,
    output logic [axi_bridge_pkg::ADDR_W-1:0] pend_addr_o,
    output axi_bridge_pkg::axi_aw_t           axi_aw_o,
    output logic                              awvalid_o,
    output axi_bridge_pkg::axi_w_t            axi_w_o,
    output logic                              wvalid_o,
    output logic                              bready_o,
    output logic                              wr_data_ack_o,
    output logic                              wr_done_o,
    output logic [1:0]                        wr_resp_o
);

    axi_bridge_pkg::wr_state_e         state_q;
    logic [7:0]                        beat_cnt_q; // beats left after the current one
    logic [axi_bridge_pkg::STRB_W-1:0] strb_q;
    logic                              w_hs;
    logic                              w_load;

    // single lane -> byte, aligned lane pair -> halfword
    function automatic logic [2:0] size_from_strb(
        input logic [axi_bridge_pkg::STRB_W-1:0] strb
    );
        case (strb)
            4'b0001, 4'b0010, 4'b0100, 4'b1000: size_from_strb = axi_bridge_pkg::SIZE_BYTE;
            4'b0011, 4'b1100:                   size_from_strb = axi_bridge_pkg::SIZE_HALF;
            default:                            size_from_strb = axi_bridge_pkg::SIZE_WORD;
        endcase
    endfunction

    assign busy_o      = (state_q != axi_bridge_pkg::WR_IDLE);
    assign pend_addr_o = axi_aw_o.addr; // valid while busy
    assign bready_o    = (state_q == axi_bridge_pkg::WR_RESP);

    assign w_hs   = wvalid_o && wready_i;
    assign w_load = (state_q == axi_bridge_pkg::WR_DATA) && !wvalid_o && wr_data_valid_i;

    assign wr_data_ack_o = w_hs && !flush_i;              // cache moves to its next word
    assign wr_done_o     = bready_o && bvalid_i && !flush_i;
    assign wr_resp_o     = axi_b_i.resp;

    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            state_q   <= axi_bridge_pkg::WR_IDLE;
            awvalid_o <= 1'b0;
            wvalid_o  <= 1'b0;
        end else begin
            case (state_q)
                axi_bridge_pkg::WR_IDLE: begin
                    if (start_i) begin
                        awvalid_o <= 1'b1;
                        state_q   <= axi_bridge_pkg::WR_ADDR;
                    end
                end
                axi_bridge_pkg::WR_ADDR: begin
                    if (awready_i) begin
                        awvalid_o <= 1'b0;
                        state_q   <= axi_bridge_pkg::WR_DATA;
                    end
                end
                axi_bridge_pkg::WR_DATA: begin
                    if (w_hs) begin
                        wvalid_o <= 1'b0; // one idle cycle while the cache advances
                        if (axi_w_o.last) begin
                            state_q <= axi_bridge_pkg::WR_RESP;
                        end
                    end else if (w_load) begin
                        wvalid_o <= 1'b1;
                    end
                end
                axi_bridge_pkg::WR_RESP: begin
                    if (bvalid_i) begin
                        state_q <= axi_bridge_pkg::WR_IDLE;
                    end
                end
                default: begin
                    state_q <= axi_bridge_pkg::WR_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == axi_bridge_pkg::WR_IDLE && start_i) begin
            axi_aw_o.addr  <= req_i.addr;
            axi_aw_o.len   <= req_i.len;
            axi_aw_o.size  <= size_from_strb(req_i.strb);
            axi_aw_o.burst <= axi_bridge_pkg::BURST_INCR;
            strb_q         <= req_i.strb;
            beat_cnt_q     <= req_i.len;
        end
        if (w_load) begin
            axi_w_o.data <= wr_data_i;
            axi_w_o.strb <= strb_q;
            axi_w_o.last <= (beat_cnt_q == 8'd0);
        end
        if (w_hs) begin
            beat_cnt_q <= beat_cnt_q - 8'd1;
        end
    end

endmodule

// ==== hw/axi_bridge_top.sv ====
`timescale 1ns/1ps

module axi_bridge_top (
    input  logic                              clk,
    input  logic                              rst_i,
    input  logic                              flush_i,
    // cache reads
    input  logic                              rd_req_valid_i,
    input  axi_bridge_pkg::rd_req_t           rd_req_i,
    output logic                              rd_req_ready_o,
    output axi_bridge_pkg::rd_beat_t          rd_beat_o,
    output logic                              rd_beat_valid_o,
    output logic                              rd_done_o,
    // cache writes
    input  logic                              wr_req_valid_i,
    input  axi_bridge_pkg::wr_req_t           wr_req_i,
    output logic                              wr_req_ready_o,
    input  logic [axi_bridge_pkg::DATA_W-1:0] wr_data_i,
    input  logic                              wr_data_valid_i,
    output logic                              wr_data_ack_o,
    output logic                              wr_done_o,
    output logic [1:0]                        wr_resp_o,
    // AXI4 master
    output axi_bridge_pkg::axi_ar_t           axi_ar_o,
    output logic                              arvalid_o,
    input  logic                              arready_i,
    input  axi_bridge_pkg::axi_r_t            axi_r_i,
    input  logic                              rvalid_i,
    output logic                              rready_o,
    output axi_bridge_pkg::axi_aw_t           axi_aw_o,
    output logic                              awvalid_o,
    input  logic                              awready_i,
    output axi_bridge_pkg::axi_w_t            axi_w_o,
    output logic                              wvalid_o,
    input  logic                              wready_i,
    input  axi_bridge_pkg::axi_b_t            axi_b_i,
    input  logic                              bvalid_i,
    output logic                              bready_o
);

    logic                              rd_start;
    logic                              wr_start;
    logic                              rd_busy;
    logic                              wr_busy;
    axi_bridge_pkg::rd_req_t           rd_req;
    axi_bridge_pkg::wr_req_t           wr_req;
    logic [axi_bridge_pkg::ADDR_W-1:0] wr_pend_addr; // for the hazard check

    cache_req_arbiter arbiter_inst (
        .clk            (clk),
        .rst_i          (rst_i),
        .flush_i        (flush_i),
        .rd_req_valid_i (rd_req_valid_i),
        .rd_req_i       (rd_req_i),
        .wr_req_valid_i (wr_req_valid_i),
        .wr_req_i       (wr_req_i),
        .rd_busy_i      (rd_busy),
        .wr_busy_i      (wr_busy),
        .wr_pend_addr_i (wr_pend_addr),
        .rd_req_ready_o (rd_req_ready_o),
        .wr_req_ready_o (wr_req_ready_o),
        .rd_start_o     (rd_start),
        .rd_req_o       (rd_req),
        .wr_start_o     (wr_start),
        .wr_req_o       (wr_req)
    );

    axi_read_engine read_engine_inst (
        .clk             (clk),
        .rst_i           (rst_i),
        .flush_i         (flush_i),
        .start_i         (rd_start),
        .req_i           (rd_req),
        .arready_i       (arready_i),
        .rvalid_i        (rvalid_i),
        .axi_r_i         (axi_r_i),
        .busy_o          (rd_busy),
        .axi_ar_o        (axi_ar_o),
        .arvalid_o       (arvalid_o),
        .rready_o        (rready_o),
        .rd_beat_o       (rd_beat_o),
        .rd_beat_valid_o (rd_beat_valid_o),
        .rd_done_o       (rd_done_o)
    );

    axi_write_engine write_engine_inst (
        .clk             (clk),
        .rst_i           (rst_i),
        .flush_i         (flush_i),
        .start_i         (wr_start),
        .req_i           (wr_req),
        .wr_data_i       (wr_data_i),
        .wr_data_valid_i (wr_data_valid_i),
        .awready_i       (awready_i),
        .wready_i        (wready_i),
        .bvalid_i        (bvalid_i),
        .axi_b_i         (axi_b_i),
        .busy_o          (wr_busy),
        .pend_addr_o     (wr_pend_addr),
        .axi_aw_o        (axi_aw_o),
        .awvalid_o       (awvalid_o),
        .axi_w_o         (axi_w_o),
        .wvalid_o        (wvalid_o),
        .bready_o        (bready_o),
        .wr_data_ack_o   (wr_data_ack_o),
        .wr_done_o       (wr_done_o),
        .wr_resp_o       (wr_resp_o)
    );

endmodule

// ==== tests/axi_mem_model.sv ====
`timescale 1ns/1ps

module axi_mem_model (
    input  logic                    clk,
    input  logic                    rst_i,
    input  axi_bridge_pkg::axi_ar_t axi_ar_i,
    input  logic                    arvalid_i,
    output logic                    arready_o,
    output axi_bridge_pkg::axi_r_t  axi_r_o,
    output logic                    rvalid_o,
    input  logic                    rready_i,
    input  axi_bridge_pkg::axi_aw_t axi_aw_i,
    input  logic                    awvalid_i,
    output logic                    awready_o,
    input  axi_bridge_pkg::axi_w_t  axi_w_i,
    input  logic                    wvalid_i,
    output logic                    wready_o,
    output axi_bridge_pkg::axi_b_t  axi_b_o,
    output logic                    bvalid_o,
    input  logic                    bready_i
);

    logic [31:0] mem [256]; // word addressed and filled by the testbench
    integer      seed = 32'h0363_44a5;
    logic        rd_active;
    logic        wr_active;
    logic        b_wait;    // last W beat taken and B not yet sent
    logic [7:0]  rd_idx;
    logic [7:0]  rd_left;
    logic [7:0]  wr_idx;
    int          rd_dly;
    int          wr_dly;

    always @(posedge clk) begin
        if (rst_i) begin
            arready_o <= 1'b0;
            rvalid_o  <= 1'b0;
            awready_o <= 1'b0;
            wready_o  <= 1'b0;
            bvalid_o  <= 1'b0;
            axi_r_o   <= '0;
            axi_b_o   <= '0;
            rd_active <= 1'b0;
            wr_active <= 1'b0;
            b_wait    <= 1'b0;
            rd_dly    <= 0;
            wr_dly    <= 0;
        end else begin
            if (arvalid_i && arready_o) begin
                arready_o <= 1'b0;
                rd_active <= 1'b1;
                rd_idx    <= axi_ar_i.addr[9:2];
                rd_left   <= axi_ar_i.len;
                rd_dly    <= $unsigned($random(seed)) % 4;
            end else if (arvalid_i && !rd_active && !arready_o) begin
                if (rd_dly == 0) arready_o <= 1'b1;
                else rd_dly <= rd_dly - 1;
            end
            if (rvalid_o && rready_i) begin
                rvalid_o  <= 1'b0;
                rd_idx    <= rd_idx + 8'd1;
                rd_left   <= rd_left - 8'd1;
                rd_active <= (rd_left != 8'd0);
                rd_dly    <= $unsigned($random(seed)) % 4;
            end else if (rd_active && !rvalid_o) begin
                if (rd_dly == 0) begin
                    rvalid_o     <= 1'b1;
                    axi_r_o.data <= mem[rd_idx];
                    axi_r_o.resp <= axi_bridge_pkg::RESP_OKAY;
                    axi_r_o.last <= (rd_left == 8'd0);
                end else begin
                    rd_dly <= rd_dly - 1;
                end
            end
            if (awvalid_i && awready_o) begin
                awready_o <= 1'b0;
                wr_active <= 1'b1;
                wr_idx    <= axi_aw_i.addr[9:2];
                wr_dly    <= $unsigned($random(seed)) % 4;
            end else if (awvalid_i && !wr_active && !awready_o) begin
                if (wr_dly == 0) awready_o <= 1'b1;
                else wr_dly <= wr_dly - 1;
            end
            if (wvalid_i && wready_o) begin
                wready_o <= 1'b0;
                for (int b = 0; b < 4; b++) begin
                    if (axi_w_i.strb[b]) mem[wr_idx][8*b +: 8] <= axi_w_i.data[8*b +: 8];
                end
                wr_idx <= wr_idx + 8'd1;
                b_wait <= axi_w_i.last;
                wr_dly <= $unsigned($random(seed)) % 4;
            end else if (wr_active && wvalid_i && !wready_o && !b_wait) begin
                if (wr_dly == 0) wready_o <= 1'b1;
                else wr_dly <= wr_dly - 1;
            end
            if (bvalid_o && bready_i) begin
                bvalid_o  <= 1'b0;
                wr_active <= 1'b0;
                b_wait    <= 1'b0;
                wr_dly    <= $unsigned($random(seed)) % 4;
            end else if (b_wait && !bvalid_o) begin
                if (wr_dly == 0) begin
                    bvalid_o     <= 1'b1;
                    axi_b_o.resp <= axi_bridge_pkg::RESP_OKAY;
                end else begin
                    wr_dly <= wr_dly - 1;
                end
            end
        end
    end

endmodule

// ==== tests/tb_axi_bridge.sv ====
`timescale 1ns/1ps

module tb_axi_bridge;

    localparam int MAX_WAIT = 200; // cycles per wait loop

    logic                     clk;
    logic                     rst;
    logic                     flush;
    logic                     rd_req_valid;
    axi_bridge_pkg::rd_req_t  rd_req;
    logic                     rd_req_ready;
    axi_bridge_pkg::rd_beat_t rd_beat;
    logic                     rd_beat_valid;
    logic                     rd_done;
    logic                     wr_req_valid;
    axi_bridge_pkg::wr_req_t  wr_req;
    logic                     wr_req_ready;
    logic [31:0]              wr_data;
    logic                     wr_data_valid;
    logic                     wr_data_ack;
    logic                     wr_done;
    logic [1:0]               wr_resp;
    axi_bridge_pkg::axi_ar_t  axi_ar;
    logic                     arvalid;
    logic                     arready;
    axi_bridge_pkg::axi_r_t   axi_r;
    logic                     rvalid;
    logic                     rready;
    axi_bridge_pkg::axi_aw_t  axi_aw;
    logic                     awvalid;
    logic                     awready;
    axi_bridge_pkg::axi_w_t   axi_w;
    logic                     wvalid;
    logic                     wready;
    axi_bridge_pkg::axi_b_t   axi_b;
    logic                     bvalid;
    logic                     bready;

    logic [31:0] ref_mem [256];
    logic [31:0] beat_buf [16]; // words of the next write burst
    logic [2:0]  aw_size_seen;
    time         rd_accept_time;
    time         wr_done_time;
    integer      seed = 32'h0363_44a5;
    int          checks = 0;
    int          errors = 0;

    // handshake rule monitor state
    logic                    ar_held = 1'b0;
    logic                    aw_held = 1'b0;
    axi_bridge_pkg::axi_ar_t ar_prev;
    axi_bridge_pkg::axi_aw_t aw_prev;

    axi_bridge_top axi_bridge_top_inst (
        .clk(clk), .rst_i(rst), .flush_i(flush),
        .rd_req_valid_i(rd_req_valid), .rd_req_i(rd_req), .rd_req_ready_o(rd_req_ready),
        .rd_beat_o(rd_beat), .rd_beat_valid_o(rd_beat_valid), .rd_done_o(rd_done),
        .wr_req_valid_i(wr_req_valid), .wr_req_i(wr_req), .wr_req_ready_o(wr_req_ready),
        .wr_data_i(wr_data), .wr_data_valid_i(wr_data_valid), .wr_data_ack_o(wr_data_ack),
        .wr_done_o(wr_done), .wr_resp_o(wr_resp),
        .axi_ar_o(axi_ar), .arvalid_o(arvalid), .arready_i(arready),
        .axi_r_i(axi_r), .rvalid_i(rvalid), .rready_o(rready),
        .axi_aw_o(axi_aw), .awvalid_o(awvalid), .awready_i(awready),
        .axi_w_o(axi_w), .wvalid_o(wvalid), .wready_i(wready),
        .axi_b_i(axi_b), .bvalid_i(bvalid), .bready_o(bready)
    );

    // the slave model also drops its bursts on a flush
    axi_mem_model mem_model_inst (
        .clk(clk), .rst_i(rst || flush),
        .axi_ar_i(axi_ar), .arvalid_i(arvalid), .arready_o(arready),
        .axi_r_o(axi_r), .rvalid_o(rvalid), .rready_i(rready),
        .axi_aw_i(axi_aw), .awvalid_i(awvalid), .awready_o(awready),
        .axi_w_i(axi_w), .wvalid_i(wvalid), .wready_o(wready),
        .axi_b_o(axi_b), .bvalid_o(bvalid), .bready_i(bready)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] fill_word(input logic [7:0] idx);
        fill_word = {idx, ~idx, idx ^ 8'h5a, idx + 8'h3c};
    endfunction

    task automatic compare_values(input logic [63:0] got, input logic [63:0] exp,
                                  input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s, got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic report_timeout(input string what);
        errors++;
        $display("timeout at %0t: no %s within %0d cycles", $time, what, MAX_WAIT);
    endtask

    task automatic report_test(input string name, input int errors_before);
        $display("test %s: %s", name, (errors == errors_before) ? "ok" : "failed");
    endtask

    // valid must stay up with a stable payload until ready
    always @(negedge clk) begin
        if (ar_held) begin
            compare_values(arvalid, 1'b1, "arvalid held until arready");
            compare_values(axi_ar, ar_prev, "ar payload stable");
        end
        if (aw_held) begin
            compare_values(awvalid, 1'b1, "awvalid held until awready");
            compare_values(axi_aw, aw_prev, "aw payload stable");
        end
        ar_held = arvalid && !arready && !flush && !rst;
        aw_held = awvalid && !awready && !flush && !rst;
        ar_prev = axi_ar;
        aw_prev = axi_aw;
    end

    task automatic send_read(input logic [31:0] addr, input logic [7:0] len);
        int t;
        @(posedge clk);
        rd_req_valid <= 1'b1;
        rd_req       <= {addr, len};
        t = 0;
        do begin
            @(negedge clk);
            t++;
        end while (!rd_req_ready && t < MAX_WAIT);
        if (!rd_req_ready) report_timeout("read request ready");
        rd_accept_time = $time;
        @(posedge clk);
        rd_req_valid <= 1'b0;
    endtask

    task automatic read_burst(input logic [31:0] addr, input logic [7:0] len);
        int t;
        int beat;
        send_read(addr, len);
        beat = 0;
        t = 0;
        while (beat <= len && t < MAX_WAIT) begin
            @(negedge clk);
            t++;
            if (arvalid) begin
                compare_values(axi_ar.len, len, "arlen");
                compare_values(axi_ar.size, axi_bridge_pkg::SIZE_WORD, "arsize");
                compare_values(axi_ar.burst, axi_bridge_pkg::BURST_INCR, "arburst");
            end
            if (rd_beat_valid) begin
                compare_values(rd_beat.data, ref_mem[addr[9:2] + beat], "read data");
                compare_values(rd_beat.resp, axi_bridge_pkg::RESP_OKAY, "read resp");
                compare_values(rd_done, beat == len, "rd_done with last beat only");
                beat++;
                t = 0;
            end
        end
        if (beat <= len) report_timeout("read beat");
    endtask

    task automatic write_burst(input logic [31:0] addr, input logic [7:0] len,
                               input logic [3:0] strb);
        int   t;
        int   acks;
        logic ack_now;
        logic done_now;
        logic done_seen;
        @(posedge clk);
        wr_req_valid <= 1'b1;
        wr_req       <= {addr, len, strb};
        t = 0;
        do begin
            @(negedge clk);
            t++;
        end while (!wr_req_ready && t < MAX_WAIT);
        if (!wr_req_ready) report_timeout("write request ready");
        @(posedge clk);
        wr_req_valid  <= 1'b0;
        wr_data       <= beat_buf[0];
        wr_data_valid <= 1'b1;
        acks = 0;
        done_seen = 1'b0;
        t = 0;
        while (!done_seen && t < MAX_WAIT) begin
            @(negedge clk);
            t++;
            ack_now  = wr_data_ack;
            done_now = wr_done;
            if (awvalid) begin
                aw_size_seen = axi_aw.size;
                compare_values(axi_aw.len, len, "awlen");
                compare_values(axi_aw.burst, axi_bridge_pkg::BURST_INCR, "awburst");
            end
            if (done_now) begin
                compare_values(wr_resp, axi_bridge_pkg::RESP_OKAY, "write response");
                wr_done_time = $time;
                done_seen = 1'b1;
            end
            if (ack_now) begin
                acks++;
                t = 0;
                @(posedge clk);
                if (acks <= len) wr_data <= beat_buf[acks];
                else wr_data_valid <= 1'b0; // whole burst handed over
            end
        end
        if (!done_seen) report_timeout("write response");
        compare_values(acks, len + 1, "wr_data_ack count");
        for (int k = 0; k <= len; k++) begin
            for (int b = 0; b < 4; b++) begin
                if (strb[b]) ref_mem[addr[9:2] + k][8*b +: 8] = beat_buf[k][8*b +: 8];
            end
        end
    endtask

    task automatic full_burst_test();
        int start;
        start = errors;
        for (int k = 0; k < 8; k++) beat_buf[k] = 32'hcafe_0000 | (k * 32'h0101);
        write_burst(32'h000, 8'd7, 4'b1111);
        compare_values(aw_size_seen, axi_bridge_pkg::SIZE_WORD, "awsize full word");
        read_burst(32'h000, 8'd7);
        report_test("full burst", start);
    endtask

    task automatic strobe_test();
        int start;
        start = errors;
        beat_buf[0] = 32'h1122_3344;
        write_burst(32'h100, 8'd0, 4'b0001);
        compare_values(aw_size_seen, axi_bridge_pkg::SIZE_BYTE, "awsize one byte");
        beat_buf[0] = 32'haabb_ccdd;
        beat_buf[1] = 32'heeff_0011;
        write_burst(32'h104, 8'd1, 4'b1100);
        compare_values(aw_size_seen, axi_bridge_pkg::SIZE_HALF, "awsize halfword");
        read_burst(32'h100, 8'd2);
        report_test("partial strobes", start);
    endtask

    task automatic hazard_test();
        int start;
        int t;
        start = errors;
        for (int k = 0; k < 4; k++) beat_buf[k] = 32'h5a5a_0000 + k;
        fork
            write_burst(32'h200, 8'd3, 4'b1111);
            begin
                t = 0;
                while (!awvalid && t < MAX_WAIT) begin
                    @(negedge clk);
                    t++;
                end
                if (!awvalid) report_timeout("awvalid before hazard read");
                read_burst(32'h200, 8'd3);
            end
        join
        compare_values(rd_accept_time > wr_done_time, 1'b1, "read held until wr_done");
        report_test("read after write", start);
    endtask

    task automatic backpressure_test();
        int          start;
        logic [7:0]  wlen;
        logic [7:0]  rlen;
        logic [31:0] raddr;
        start = errors;
        for (int r = 0; r < 6; r++) begin
            wlen = $unsigned($random(seed)) % 8;
            rlen = $unsigned($random(seed)) % 8;
            for (int k = 0; k < 8; k++) beat_buf[k] = $random(seed);
            // read back the previous round's region while writing a new one
            raddr = (r == 0) ? 32'h080 : (128 + 16 * (r - 1)) * 4;
            fork
                write_burst((128 + 16 * r) * 4, wlen, 4'b1111);
                read_burst(raddr, rlen);
            join
        end
        report_test("back-pressure", start);
    endtask

    task automatic flush_test();
        int   start;
        int   t;
        logic seen;
        start = errors;
        send_read(32'h300, 8'd7);
        seen = 1'b0;
        t = 0;
        while (!seen && t < MAX_WAIT) begin
            @(negedge clk);
            t++;
            seen = rd_beat_valid;
        end
        if (!seen) report_timeout("read beat before flush");
        @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        @(negedge clk);
        compare_values({arvalid, rready, rd_beat_valid, rd_done}, 4'b0, "read side after flush");
        t = 0;
        while (!(rd_req_ready && wr_req_ready) && t < MAX_WAIT) begin
            @(negedge clk);
            t++;
        end
        compare_values({rd_req_ready, wr_req_ready}, 2'b11, "both ready after flush");
        compare_values({arvalid, rready, rd_beat_valid}, 3'b0, "read side idle");
        read_burst(32'h000, 8'd3);
        beat_buf[0] = 32'h0bad_f00d;
        beat_buf[1] = 32'h7777_1234;
        write_burst(32'h380, 8'd1, 4'b0011);
        read_burst(32'h380, 8'd1);
        report_test("flush", start);
    endtask

    initial begin
        clk           = 1'b0;
        rst           = 1'b1;
        flush         = 1'b0;
        rd_req_valid  = 1'b0;
        rd_req        = '0;
        wr_req_valid  = 1'b0;
        wr_req        = '0;
        wr_data       = '0;
        wr_data_valid = 1'b0;
        for (int i = 0; i < 256; i++) begin
            ref_mem[i] = fill_word(i[7:0]);
            mem_model_inst.mem[i] = ref_mem[i];
        end
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        full_burst_test();
        strobe_test();
        hazard_test();
        backpressure_test();
        flush_test();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== src.f ====
common/axi_bridge_pkg.sv
hw/cache_req_arbiter.sv
axi_read/axi_read_engine.sv
axi_write/axi_write_engine.sv
hw/axi_bridge_top.sv
tests/axi_mem_model.sv
tests/tb_axi_bridge.sv
